/* design/cache_pkg.sv */
package cache_pkg;

    // cache geometry.
    localparam int NUM_BANKS         = 2;
    localparam int BANKS_LEN         = 1;
    localparam int NUM_WAYS          = 2;
    localparam int WAYS_LEN          = 1;
    localparam int NUM_SETS_PER_BANK = 4;
    localparam int SET_LEN           = 2;
    localparam int BLOCK_SIZE        = 4;
    localparam int BLOCK_OFF_LEN     = 2;
    localparam int INDEX_LEN         = 3;
    localparam int TAG_LEN           = 25;
    localparam int UUID_LEN          = 4;
    localparam int WORD_LEN          = 32;
    localparam int AGE_LEN           = 4;

    // low index bit picks the bank.
    typedef struct packed {
        logic [TAG_LEN-1:0]       tag;
        logic [INDEX_LEN-1:0]     index;
        logic [BLOCK_OFF_LEN-1:0] block_offset;
        logic [1:0]               byte_offset;
    } cache_addr;

    typedef struct packed {
        logic                rw_mode;
        cache_addr           addr;
        logic [WORD_LEN-1:0] store_value;
        logic [UUID_LEN-1:0] uuid;
    } mem_instr;

    typedef struct packed {
        logic                  valid;
        cache_addr             block_addr;
        logic [BLOCK_SIZE-1:0] write_status;
        logic [WORD_LEN-1:0]   store_value;
        logic [UUID_LEN-1:0]   uuid;
    } mshr_reg;

    typedef struct packed {
        logic                                valid;
        logic                                dirty;
        logic [TAG_LEN-1:0]                  tag;
        logic [BLOCK_SIZE-1:0][WORD_LEN-1:0] block;
    } cache_frame;

    typedef struct packed {
        logic [NUM_WAYS-1:0][AGE_LEN-1:0] age;
        logic [WAYS_LEN-1:0]              lru_way;
    } lru_frame;

    typedef struct packed {
        logic [UUID_LEN-1:0] uuid;
        logic [WORD_LEN-1:0] data;
    } resp_entry;

endpackage

/* design/request_dispatch.sv */
`timescale 1ns/100ps

module request_dispatch (
    input  logic CLK,
    input  logic nRST,
    input  logic req_valid,
    input  logic req_write,
    input  logic [31:0] req_addr,
    input  logic [cache_pkg::WORD_LEN-1:0] req_data,
    input  logic [cache_pkg::UUID_LEN-1:0] req_uuid,
    input  logic [cache_pkg::NUM_BANKS-1:0] bank_hit,
    input  logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::WORD_LEN-1:0] bank_hit_data,
    input  logic [cache_pkg::NUM_BANKS-1:0] bank_busy,
    input  logic [cache_pkg::NUM_BANKS-1:0] mshr_valid,
    input  logic nearly_full,
    output logic req_ready,
    output cache_pkg::mem_instr instr,
    output logic [cache_pkg::NUM_BANKS-1:0] instr_valid,
    output logic [cache_pkg::NUM_BANKS-1:0] allocate,
    output logic hit_push,
    output cache_pkg::resp_entry hit_resp
);

    logic [cache_pkg::BANKS_LEN-1:0] sel;
    logic accept;

    assign instr.rw_mode     = req_write;
    assign instr.addr        = cache_pkg::cache_addr'(req_addr);
    assign instr.store_value = req_data;
    assign instr.uuid        = req_uuid;

    assign sel = instr.addr.index[cache_pkg::BANKS_LEN-1:0];

    // a miss needs a free MSHR, a hit does not.
    assign req_ready = !nearly_full && !bank_busy[sel] && (bank_hit[sel] || !mshr_valid[sel]);
    assign accept    = req_valid && req_ready;

    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            instr_valid[b] = accept && (sel == cache_pkg::BANKS_LEN'(b));
            allocate[b]    = instr_valid[b] && !bank_hit[b];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            hit_push <= 1'b0;
        end else begin
            hit_push <= accept && bank_hit[sel];
        end
    end

    // stores answer with the value written.
    always_ff @(posedge CLK) begin
        if (accept) begin
            hit_resp.uuid <= req_uuid;
            hit_resp.data <= req_write ? req_data : bank_hit_data[sel];
        end
    end

endmodule

/* design/mshr_file.sv */
`timescale 1ns/100ps

module mshr_file (
    input  logic CLK,
    input  logic nRST,
    input  logic [cache_pkg::NUM_BANKS-1:0] allocate,
    input  cache_pkg::mem_instr instr,
    input  logic [cache_pkg::NUM_BANKS-1:0] fill_done,
    output cache_pkg::mshr_reg [cache_pkg::NUM_BANKS-1:0] mshr_entry
);

    logic [cache_pkg::NUM_BANKS-1:0] valid;
    cache_pkg::cache_addr [cache_pkg::NUM_BANKS-1:0] block_addr;
    logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::BLOCK_SIZE-1:0] write_status;
    logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::WORD_LEN-1:0] store_value;
    logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::UUID_LEN-1:0] uuid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
        end else begin
            for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
                if (allocate[b]) begin
                    valid[b] <= 1'b1;
                end else if (fill_done[b]) begin
                    valid[b] <= 1'b0;
                end
            end
        end
    end

    // block_offset is kept, it picks the word returned on fill.
    always_ff @(posedge CLK) begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            if (allocate[b]) begin
                block_addr[b]  <= instr.addr;
                store_value[b] <= instr.store_value;
                uuid[b]        <= instr.uuid;
                if (instr.rw_mode) begin
                    write_status[b] <= cache_pkg::BLOCK_SIZE'(1) << instr.addr.block_offset;
                end else begin
                    write_status[b] <= '0;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            mshr_entry[b].valid        = valid[b];
            mshr_entry[b].block_addr   = block_addr[b];
            mshr_entry[b].write_status = write_status[b];
            mshr_entry[b].store_value  = store_value[b];
            mshr_entry[b].uuid         = uuid[b];
        end
    end

endmodule

/* design/cache_bank.sv */
`timescale 1ns/100ps

module cache_bank #(
    parameter int BANK_ID = 0
) (
    input  logic CLK,
    input  logic nRST,
    input  logic instr_valid,
    input  cache_pkg::mem_instr instr,
    input  cache_pkg::mshr_reg mshr_entry,
    input  logic [cache_pkg::WORD_LEN-1:0] ram_data,
    input  logic ram_complete,
    output logic hit,
    output logic [cache_pkg::WORD_LEN-1:0] hit_data,
    output logic busy,
    output logic ram_ren,
    output logic ram_wen,
    output logic [31:0] ram_addr,
    output logic [cache_pkg::WORD_LEN-1:0] ram_store,
    output logic fill_done,
    output logic [cache_pkg::UUID_LEN-1:0] fill_uuid,
    output logic [cache_pkg::WORD_LEN-1:0] fill_data
);

    typedef enum logic [1:0] {START, BLOCK_PULL, VICTIM_EJECT, FINISH} state_t;

    state_t state, next_state;
    logic [cache_pkg::BLOCK_OFF_LEN-1:0] count;
    cache_pkg::cache_frame [cache_pkg::NUM_SETS_PER_BANK-1:0][cache_pkg::NUM_WAYS-1:0] frames;
    cache_pkg::cache_frame [cache_pkg::NUM_SETS_PER_BANK-1:0][cache_pkg::NUM_WAYS-1:0] next_frames;
    cache_pkg::lru_frame [cache_pkg::NUM_SETS_PER_BANK-1:0] lru, next_lru;
    cache_pkg::cache_frame victim;
    logic [cache_pkg::BLOCK_SIZE-1:0][cache_pkg::WORD_LEN-1:0] pull_buf, fill_block;
    logic [cache_pkg::SET_LEN-1:0] req_set, miss_set, touch_set;
    logic [cache_pkg::WAYS_LEN-1:0] hit_way, miss_way, victim_way, touch_way;
    logic last_word;

    assign req_set   = instr.addr.index[cache_pkg::INDEX_LEN-1:cache_pkg::BANKS_LEN];
    assign miss_set  = mshr_entry.block_addr.index[cache_pkg::INDEX_LEN-1:cache_pkg::BANKS_LEN];
    assign last_word = ram_complete && (count == cache_pkg::BLOCK_OFF_LEN'(cache_pkg::BLOCK_SIZE - 1));

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
            if (frames[req_set][i].valid && (frames[req_set][i].tag == instr.addr.tag)) begin
                hit     = 1'b1;
                hit_way = cache_pkg::WAYS_LEN'(i);
            end
        end
        hit_data = frames[req_set][hit_way].block[instr.addr.block_offset];
    end

    // an empty way beats the LRU way.
    always_comb begin
        miss_way = lru[miss_set].lru_way;
        for (int i = cache_pkg::NUM_WAYS - 1; i >= 0; i--) begin
            if (!frames[miss_set][i].valid) miss_way = cache_pkg::WAYS_LEN'(i);
        end
    end

    // pulled words with the miss's store merged in.
    always_comb begin
        for (int w = 0; w < cache_pkg::BLOCK_SIZE; w++) begin
            fill_block[w] = mshr_entry.write_status[w] ? mshr_entry.store_value : pull_buf[w];
        end
    end

    assign fill_uuid = mshr_entry.uuid;
    assign fill_data = fill_block[mshr_entry.block_addr.block_offset];

    always_comb begin
        next_frames = frames;
        if (instr_valid && hit && instr.rw_mode) begin
            next_frames[req_set][hit_way].block[instr.addr.block_offset] = instr.store_value;
            next_frames[req_set][hit_way].dirty = 1'b1;
        end
        if ((state == START) && mshr_entry.valid) begin
            next_frames[miss_set][miss_way].valid = 1'b0;
        end
        if (state == FINISH) begin
            next_frames[miss_set][victim_way].valid = 1'b1;
            next_frames[miss_set][victim_way].dirty = |mshr_entry.write_status;
            next_frames[miss_set][victim_way].tag   = mshr_entry.block_addr.tag;
            next_frames[miss_set][victim_way].block = fill_block;
        end
    end

    // touched way goes to age zero, the others grow older.
    always_comb begin
        next_lru  = lru;
        touch_set = (state == FINISH) ? miss_set : req_set;
        touch_way = (state == FINISH) ? victim_way : hit_way;
        if ((instr_valid && hit) || (state == FINISH)) begin
            next_lru[touch_set].lru_way = touch_way;
            for (int j = 0; j < cache_pkg::NUM_WAYS; j++) begin
                if (cache_pkg::WAYS_LEN'(j) == touch_way) begin
                    next_lru[touch_set].age[j] = '0;
                end else if (lru[touch_set].age[j] != '1) begin
                    next_lru[touch_set].age[j] = lru[touch_set].age[j] + 1'b1;
                end
            end
            for (int j = 0; j < cache_pkg::NUM_WAYS; j++) begin
                if ((cache_pkg::WAYS_LEN'(j) != touch_way) &&
                    ((next_lru[touch_set].lru_way == touch_way) ||
                     (next_lru[touch_set].age[j] >
                      next_lru[touch_set].age[next_lru[touch_set].lru_way]))) begin
                    next_lru[touch_set].lru_way = cache_pkg::WAYS_LEN'(j);
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        busy       = 1'b1;
        ram_ren    = 1'b0;
        ram_wen    = 1'b0;
        fill_done  = 1'b0;
        ram_addr   = {mshr_entry.block_addr.tag, mshr_entry.block_addr.index, count, 2'b00};
        ram_store  = victim.block[count];
        case (state)
            START: begin
                busy = mshr_entry.valid;
                if (mshr_entry.valid) next_state = BLOCK_PULL;
            end
            BLOCK_PULL: begin
                ram_ren = 1'b1;
                if (last_word) begin
                    next_state = (victim.valid && victim.dirty) ? VICTIM_EJECT : FINISH;
                end
            end
            VICTIM_EJECT: begin
                ram_wen  = 1'b1;
                ram_addr = {victim.tag, miss_set, cache_pkg::BANKS_LEN'(BANK_ID), count, 2'b00};
                if (last_word) next_state = FINISH;
            end
            default: begin
                fill_done  = 1'b1;
                next_state = START;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= START;
            count  <= '0;
            frames <= '0;
            lru    <= '0;
        end else begin
            state  <= next_state;
            frames <= next_frames;
            lru    <= next_lru;
            if (ram_complete && ((state == BLOCK_PULL) || (state == VICTIM_EJECT))) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == START) && mshr_entry.valid) begin
            victim     <= frames[miss_set][miss_way];
            victim_way <= miss_way;
        end
        if ((state == BLOCK_PULL) && ram_complete) begin
            pull_buf[count] <= ram_data;
        end
    end

endmodule

/* design/ram_arbiter.sv */
`timescale 1ns/100ps

module ram_arbiter (
    input  logic CLK,
    input  logic nRST,
    input  logic [cache_pkg::NUM_BANKS-1:0] ren,
    input  logic [cache_pkg::NUM_BANKS-1:0] wen,
    input  logic [cache_pkg::NUM_BANKS-1:0][31:0] addr,
    input  logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::WORD_LEN-1:0] store,
    input  logic ram_complete,
    input  logic [cache_pkg::WORD_LEN-1:0] ram_data,
    output logic [cache_pkg::NUM_BANKS-1:0] complete,
    output logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::WORD_LEN-1:0] data,
    output logic ram_ren,
    output logic ram_wen,
    output logic [31:0] ram_addr,
    output logic [cache_pkg::WORD_LEN-1:0] ram_store
);

    logic [cache_pkg::BANKS_LEN-1:0] owner, next_owner;
    logic [cache_pkg::NUM_BANKS-1:0] req;

    assign req       = ren | wen;
    assign ram_ren   = ren[owner];
    assign ram_wen   = wen[owner];
    assign ram_addr  = addr[owner];
    assign ram_store = store[owner];

    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            complete[b] = ram_complete && (owner == cache_pkg::BANKS_LEN'(b));
            data[b]     = ram_data;
        end
    end

    // hand over after a complete, or when the owner has gone idle.
    always_comb begin
        next_owner = owner;
        if (ram_complete || !req[owner]) begin
            for (int i = cache_pkg::NUM_BANKS - 1; i >= 1; i--) begin
                if (req[cache_pkg::BANKS_LEN'(owner + i)]) begin
                    next_owner = cache_pkg::BANKS_LEN'(owner + i);
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= '0;
        end else begin
            owner <= next_owner;
        end
    end

endmodule

/* design/response_queue.sv */
`timescale 1ns/100ps

module response_queue #(
    parameter int DEPTH = 8
) (
    input  logic CLK,
    input  logic nRST,
    input  logic hit_push,
    input  cache_pkg::resp_entry hit_resp,
    input  logic [cache_pkg::NUM_BANKS-1:0] fill_push,
    input  cache_pkg::resp_entry [cache_pkg::NUM_BANKS-1:0] fill_resp,
    output logic nearly_full,
    output logic resp_valid,
    output logic [cache_pkg::UUID_LEN-1:0] resp_uuid,
    output logic [cache_pkg::WORD_LEN-1:0] resp_data
);

    localparam int PTR_LEN = $clog2(DEPTH);

    cache_pkg::resp_entry mem [DEPTH];
    cache_pkg::resp_entry first, head;
    logic [PTR_LEN-1:0] wr_ptr, rd_ptr;
    logic [PTR_LEN:0] count;
    logic [1:0] n_push;

    // hit goes first, then fills in bank order.
    always_comb begin
        n_push = {1'b0, hit_push};
        first  = hit_resp;
        for (int b = cache_pkg::NUM_BANKS - 1; b >= 0; b--) begin
            n_push = n_push + fill_push[b];
            if (fill_push[b] && !hit_push) first = fill_resp[b];
        end
    end

    // empty queue forwards the first push straight to the head.
    assign head        = (count == '0) ? first : mem[rd_ptr];
    assign resp_valid  = (count != '0) || (n_push != '0);
    assign resp_uuid   = head.uuid;
    assign resp_data   = head.data;
    assign nearly_full = count > (DEPTH - 3);

    always_ff @(posedge CLK) begin
        logic [PTR_LEN-1:0] slot;
        slot = wr_ptr;
        if (hit_push) begin
            mem[slot] <= hit_resp;
            slot = slot + 1'b1;
        end
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            if (fill_push[b]) begin
                mem[slot] <= fill_resp[b];
                slot = slot + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_LEN'(n_push);
            rd_ptr <= rd_ptr + resp_valid;
            count  <= count + n_push - resp_valid;
        end
    end

endmodule

/* design/banked_cache.sv */
`timescale 1ns/100ps

module banked_cache #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic CLK,
    input  logic nRST,
    input  logic req_valid,
    input  logic req_write,
    input  logic [31:0] req_addr,
    input  logic [cache_pkg::WORD_LEN-1:0] req_data,
    input  logic [cache_pkg::UUID_LEN-1:0] req_uuid,
    output logic req_ready,
    output logic ram_ren,
    output logic ram_wen,
    output logic [31:0] ram_addr,
    output logic [cache_pkg::WORD_LEN-1:0] ram_store,
    input  logic ram_complete,
    input  logic [cache_pkg::WORD_LEN-1:0] ram_data,
    output logic resp_valid,
    output logic [cache_pkg::UUID_LEN-1:0] resp_uuid,
    output logic [cache_pkg::WORD_LEN-1:0] resp_data
);

    localparam int NB = cache_pkg::NUM_BANKS;

    cache_pkg::mem_instr instr;
    cache_pkg::resp_entry hit_resp;
    cache_pkg::resp_entry [NB-1:0] fill_resp;
    cache_pkg::mshr_reg [NB-1:0] mshr_entry;
    logic [NB-1:0] instr_valid, allocate, bank_hit, bank_busy, mshr_valid, fill_done;
    logic [NB-1:0] bank_ren, bank_wen, bank_complete;
    logic [NB-1:0][31:0] bank_addr;
    logic [NB-1:0][cache_pkg::WORD_LEN-1:0] bank_hit_data, bank_store, bank_data, fill_data;
    logic [NB-1:0][cache_pkg::UUID_LEN-1:0] fill_uuid;
    logic nearly_full, hit_push;

    request_dispatch u_dispatch (
        .CLK, .nRST, .req_valid, .req_write, .req_addr, .req_data, .req_uuid,
        .bank_hit, .bank_hit_data, .bank_busy, .mshr_valid, .nearly_full,
        .req_ready, .instr, .instr_valid, .allocate, .hit_push, .hit_resp
    );

    mshr_file u_mshr (.CLK, .nRST, .allocate, .instr, .fill_done, .mshr_entry);

    for (genvar b = 0; b < NB; b++) begin : g_bank
        assign mshr_valid[b] = mshr_entry[b].valid;
        assign fill_resp[b]  = {fill_uuid[b], fill_data[b]};

        cache_bank #(.BANK_ID(b)) u_bank (
            .CLK, .nRST, .instr_valid(instr_valid[b]), .instr, .mshr_entry(mshr_entry[b]),
            .ram_data(bank_data[b]), .ram_complete(bank_complete[b]),
            .hit(bank_hit[b]), .hit_data(bank_hit_data[b]), .busy(bank_busy[b]),
            .ram_ren(bank_ren[b]), .ram_wen(bank_wen[b]), .ram_addr(bank_addr[b]),
            .ram_store(bank_store[b]), .fill_done(fill_done[b]),
            .fill_uuid(fill_uuid[b]), .fill_data(fill_data[b])
        );
    end

    ram_arbiter u_arbiter (
        .CLK, .nRST, .ren(bank_ren), .wen(bank_wen), .addr(bank_addr), .store(bank_store),
        .ram_complete, .ram_data, .complete(bank_complete), .data(bank_data),
        .ram_ren, .ram_wen, .ram_addr, .ram_store
    );

    response_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
        .CLK, .nRST, .hit_push, .hit_resp, .fill_push(fill_done), .fill_resp,
        .nearly_full, .resp_valid, .resp_uuid, .resp_data
    );

endmodule

/* bench/cache_tb_model.sv */
`timescale 1ns/100ps

module cache_tb_model (
    input  logic CLK,
    input  logic nRST,
    input  logic hold,
    input  logic req_valid,
    input  logic req_ready,
    input  logic req_write,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_data,
    input  logic ram_ren,
    input  logic ram_wen,
    input  logic [31:0] ram_addr,
    input  logic [31:0] ram_store,
    input  logic [31:0] peek_addr,
    output logic ram_complete,
    output logic [31:0] ram_data,
    output logic [31:0] ref_req,
    output logic [31:0] ref_ram,
    output logic [31:0] peek_data
);

    localparam int WORDS = 512;

    logic [31:0] ram_img [WORDS];
    logic [31:0] ref_img [WORDS];
    logic active;
    logic [1:0] wait_cnt;
    integer seed = 28202;

    // every word of the pool starts with a value of its own.
    function automatic logic [31:0] fill_word(input int i);
        return 32'h5a00_0000 ^ (32'(i) * 32'h0001_0003);
    endfunction

    assign ref_req   = ref_img[req_addr[10:2]];
    assign ref_ram   = ref_img[ram_addr[10:2]];
    assign peek_data = ram_img[peek_addr[10:2]];

    // reference follows accepted stores.
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < WORDS; i++) begin
                ref_img[i] <= fill_word(i);
            end
        end else if (req_valid && req_ready && req_write) begin
            ref_img[req_addr[10:2]] <= req_data;
        end
    end

    // one access at a time, 1 to 4 cycles, frozen while hold is high.
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ram_complete <= 1'b0;
            ram_data     <= '0;
            active       <= 1'b0;
            wait_cnt     <= '0;
            for (int i = 0; i < WORDS; i++) begin
                ram_img[i] <= fill_word(i);
            end
        end else begin
            ram_complete <= 1'b0;
            if (ram_complete) begin
                active <= 1'b0;
            end else if (!active && (ram_ren || ram_wen)) begin
                active   <= 1'b1;
                wait_cnt <= 2'($random(seed));
            end else if (active && !hold) begin
                if (wait_cnt == '0) begin
                    ram_complete <= 1'b1;
                    if (ram_wen) begin
                        ram_img[ram_addr[10:2]] <= ram_store;
                    end else begin
                        ram_data <= ram_img[ram_addr[10:2]];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* bench/banked_cache_tb.sv */
`timescale 1ns/100ps

module banked_cache_tb;

    localparam int RANDOM_OPS      = 600;
    localparam int OP_CYCLES       = 40;
    localparam int DIRECTED_CYCLES = 3000;
    localparam int UUIDS           = 1 << cache_pkg::UUID_LEN;

    logic CLK;
    logic nRST;
    logic req_valid, req_write, req_ready;
    logic [31:0] req_addr, req_data;
    logic [cache_pkg::UUID_LEN-1:0] req_uuid, resp_uuid, next_uuid;
    logic ram_ren, ram_wen, ram_complete, resp_valid, hold;
    logic [31:0] ram_addr, ram_store, ram_data, resp_data;
    logic [31:0] ref_req, ref_ram, peek_addr, peek_data;
    logic pending [UUIDS];
    logic [31:0] expected [UUIDS];
    integer seed;

    banked_cache #(.QUEUE_DEPTH(8)) uut (.*);

    cache_tb_model u_model (.*);

    always #4 CLK = ~CLK;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // tag in bits 8:7 keeps the pool inside the model RAM.
    function automatic logic [31:0] pool_addr(input logic [1:0] tag, input logic [2:0] index,
                                              input logic [1:0] offset);
        return {23'd0, tag, index, offset, 2'b00};
    endfunction

    function automatic logic any_pending();
        logic found;
        found = 1'b0;
        for (int i = 0; i < UUIDS; i++) begin
            found = found | pending[i];
        end
        return found;
    endfunction

    task automatic check_reset_outputs();
        assert (!ram_ren && !ram_wen && !resp_valid) else begin
            $display("FAILED reset outputs: ram_ren %h ram_wen %h resp_valid %h",
                     ram_ren, ram_wen, resp_valid);
            abort_run();
        end
    endtask

    // holds the request until accepted and records what it must return.
    task automatic send_request(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, output logic [3:0] uuid);
        logic taken;
        taken = 1'b0;
        while (pending[next_uuid]) begin
            req_valid <= 1'b0;
            @(posedge CLK);
        end
        uuid = next_uuid;
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_data  <= data;
        req_uuid  <= next_uuid;
        while (!taken) begin
            @(negedge CLK);
            if (req_ready) begin
                taken          = 1'b1;
                pending[uuid]  = 1'b1;
                expected[uuid] = write ? data : ref_req;
            end
            @(posedge CLK);
        end
        next_uuid = next_uuid + 1'b1;
    endtask

    task automatic drain();
        req_valid <= 1'b0;
        while (any_pending()) begin
            @(posedge CLK);
        end
    endtask

    always @(negedge CLK) begin
        if (nRST && resp_valid) begin
            assert (pending[resp_uuid]) else begin
                $display("response carries uuid %h, which is not in flight", resp_uuid);
                abort_run();
            end
            assert (resp_data == expected[resp_uuid]) else begin
                $display("FAILED resp_data for uuid %h: got %h, expected %h",
                         resp_uuid, resp_data, expected[resp_uuid]);
                abort_run();
            end
            pending[resp_uuid] = 1'b0;
        end
        if (nRST && (ram_ren || ram_wen)) begin
            assert (ram_addr[1:0] == 2'b00) else begin
                $display("FAILED ram_addr: %h is not word aligned", ram_addr);
                abort_run();
            end
            assert (ram_addr[31:11] == '0) else begin
                $display("RAM access at %h lies outside the address pool", ram_addr);
                abort_run();
            end
        end
        if (nRST && ram_complete && ram_wen) begin
            assert (ram_store == ref_ram) else begin
                $display("FAILED ram_store at %h: got %h, expected %h",
                         ram_addr, ram_store, ref_ram);
                abort_run();
            end
        end
    end

    initial begin
        repeat (RANDOM_OPS * OP_CYCLES + DIRECTED_CYCLES) @(posedge CLK);
        $display("timeout: the run did not end within %0d cycles",
                 RANDOM_OPS * OP_CYCLES + DIRECTED_CYCLES);
        abort_run();
    end

    initial begin
        logic [3:0] u;
        logic [3:0] miss_uuid;
        logic [3:0] line_uuid [3];
        logic [31:0] rnd;
        seed      = 28202;
        CLK       = 1'b0;
        nRST      = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        req_uuid  = '0;
        hold      = 1'b0;
        peek_addr = '0;
        next_uuid = '0;
        for (int i = 0; i < UUIDS; i++) begin
            pending[i]  = 1'b0;
            expected[i] = '0;
        end
        repeat (16) begin
            @(negedge CLK);
            check_reset_outputs();
        end
        @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_reset_outputs();
        @(posedge CLK);

        // three tags per set, so conflicts and dirty evictions occur.
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd = $random(seed);
            if (rnd[17:16] == 2'b00) begin
                req_valid <= 1'b0;
                @(posedge CLK);
            end
            send_request(rnd[13], pool_addr(2'(rnd[7:0] % 3), rnd[10:8], rnd[12:11]),
                         $random(seed), u);
        end
        drain();

        // store to A, then B and C push A out of bank 0, set 3.
        send_request(1'b1, pool_addr(2'd0, 3'd6, 2'd1), 32'hc0ff_ee01, u);
        send_request(1'b0, pool_addr(2'd1, 3'd6, 2'd1), '0, u);
        send_request(1'b0, pool_addr(2'd2, 3'd6, 2'd2), '0, u);
        send_request(1'b0, pool_addr(2'd0, 3'd6, 2'd1), '0, u);
        drain();
        peek_addr <= pool_addr(2'd0, 3'd6, 2'd1);
        @(negedge CLK);
        assert (peek_data == 32'hc0ff_ee01) else begin
            $display("FAILED RAM image at %h: got %h, expected %h",
                     peek_addr, peek_data, 32'hc0ff_ee01);
            abort_run();
        end
        @(posedge CLK);

        // hits in bank 1 while a bank 0 miss waits on RAM.
        send_request(1'b0, pool_addr(2'd1, 3'd5, 2'd0), '0, u);
        drain();
        hold <= 1'b1;
        send_request(1'b0, pool_addr(2'd3, 3'd2, 2'd3), '0, miss_uuid);
        for (int k = 0; k < 3; k++) begin
            send_request(1'b0, pool_addr(2'd1, 3'd5, 2'(k)), '0, line_uuid[k]);
        end
        req_valid <= 1'b0;
        for (int k = 0; k < 3; k++) begin
            while (pending[line_uuid[k]]) begin
                @(posedge CLK);
            end
        end
        assert (pending[miss_uuid]) else begin
            $display("bank 0 miss was answered while RAM completes were held off");
            abort_run();
        end
        hold <= 1'b0;
        drain();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* list.f */
design/cache_pkg.sv
design/request_dispatch.sv
design/mshr_file.sv
design/cache_bank.sv
design/ram_arbiter.sv
design/response_queue.sv
design/banked_cache.sv
bench/cache_tb_model.sv
bench/banked_cache_tb.sv
